// File: src/rvIsaPkg.sv
package rvIsaPkg;

    localparam int XLEN        = 64;
    localparam int InstWidth   = 32;
    localparam int RegIdxWidth = 5;

    // Base RV64I major opcodes handled by the decode stage.
    typedef enum logic [6:0] {
        OpLoad   = 7'b0000011,
        OpImm    = 7'b0010011,
        OpAuipc  = 7'b0010111,
        OpImmW   = 7'b0011011,
        OpStore  = 7'b0100011,
        OpR      = 7'b0110011,
        OpLui    = 7'b0110111,
        OpRW     = 7'b0111011,
        OpBranch = 7'b1100011,
        OpJalr   = 7'b1100111,
        OpJal    = 7'b1101111
    } opcode_e;

    // ALU funct3, shared by the register and immediate forms.
    localparam logic [2:0] F3Add  = 3'b000; // Also SUB through funct7.
    localparam logic [2:0] F3Sll  = 3'b001;
    localparam logic [2:0] F3Slt  = 3'b010;
    localparam logic [2:0] F3Sltu = 3'b011;
    localparam logic [2:0] F3Xor  = 3'b100;
    localparam logic [2:0] F3Sr   = 3'b101; // SRL and SRA.
    localparam logic [2:0] F3Or   = 3'b110;
    localparam logic [2:0] F3And  = 3'b111;

    localparam logic [2:0] F3Lb  = 3'b000;
    localparam logic [2:0] F3Lh  = 3'b001;
    localparam logic [2:0] F3Lw  = 3'b010;
    localparam logic [2:0] F3Ld  = 3'b011;
    localparam logic [2:0] F3Lbu = 3'b100;
    localparam logic [2:0] F3Lhu = 3'b101;
    localparam logic [2:0] F3Lwu = 3'b110;

    localparam logic [2:0] F3Sb = 3'b000;
    localparam logic [2:0] F3Sh = 3'b001;
    localparam logic [2:0] F3Sw = 3'b010;
    localparam logic [2:0] F3Sd = 3'b011;

    localparam logic [2:0] F3Beq  = 3'b000;
    localparam logic [2:0] F3Bne  = 3'b001;
    localparam logic [2:0] F3Blt  = 3'b100;
    localparam logic [2:0] F3Bge  = 3'b101;
    localparam logic [2:0] F3Bltu = 3'b110;
    localparam logic [2:0] F3Bgeu = 3'b111;

    localparam logic [2:0] F3Jalr = 3'b000;

    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Alt  = 7'b0100000; // SUB and SRA.

    // RV64 shift immediates take a 6-bit shamt, leaving funct6 above it.
    localparam logic [5:0] F6Base = 6'b000000;
    localparam logic [5:0] F6Alt  = 6'b010000;

    typedef struct packed {
        opcode_e                opcode;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        logic [RegIdxWidth-1:0] rd;
        logic [RegIdxWidth-1:0] rs1;
        logic [RegIdxWidth-1:0] rs2;
        logic [XLEN-1:0]        imm;
    } instFields_t;

endpackage

// File: src/idCtrlPkg.sv
package idCtrlPkg;

    typedef enum logic [4:0] {
        ExeNop,
        Add,
        Sub,
        Sll,
        Srl,
        Sra,
        Xor,
        Or,
        And,
        Slt,
        Sltu,
        AddW,
        SubW,
        SllW,
        SrlW,
        SraW
    } exeOp_e;

    // Where the execute stage takes its two operands from.
    typedef enum logic [1:0] {
        SrcNop,
        SrcRegReg,
        SrcRegImm,
        SrcPcImm
    } exeSrc_e;

    typedef enum logic [3:0] {
        MemNop,
        Lb, Lh, Lw, Ld,
        Lbu, Lhu, Lwu,
        Sb, Sh, Sw, Sd
    } memOp_e;

    typedef enum logic [2:0] {
        WbNone,
        WbExe,
        WbMem,
        WbSnpc, // Link value pc + 4 for JAL and JALR.
        WbImm   // LUI writes the U immediate directly.
    } wbSel_e;

    typedef enum logic {
        TrapNone,
        TrapIllegal
    } trap_e;

    typedef struct packed {
        exeOp_e  exeOp;
        exeSrc_e exeSrc;
        memOp_e  memOp;
        wbSel_e  wbSel;
        trap_e   trap;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                             ctrl;
        logic [rvIsaPkg::RegIdxWidth-1:0]  rd;
        logic [rvIsaPkg::XLEN-1:0]         rs1Data;
        logic [rvIsaPkg::XLEN-1:0]         rs2Data;
        logic [rvIsaPkg::XLEN-1:0]         imm;
        logic [rvIsaPkg::XLEN-1:0]         pc;
        logic [rvIsaPkg::XLEN-1:0]         nextPc;
        logic                              redirect;
    } idExe_t;

endpackage

// File: src/instFields.sv
`timescale 1ns/1ps

module instFields (
    input  logic [rvIsaPkg::InstWidth-1:0] inst,
    output rvIsaPkg::instFields_t          fields
);
    import rvIsaPkg::*;

    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;

    // Bit 31 always carries the sign, whatever the format.
    assign immI = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign immS = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        fields.opcode = opcode_e'(inst[6:0]);
        fields.funct3 = inst[14:12];
        fields.funct7 = inst[31:25];
        fields.rd     = inst[11:7];
        fields.rs1    = inst[19:15];
        fields.rs2    = inst[24:20];
        case (opcode_e'(inst[6:0]))
            OpImm, OpImmW, OpLoad, OpJalr: fields.imm = immI;
            OpStore:                       fields.imm = immS;
            OpBranch:                      fields.imm = immB;
            OpLui, OpAuipc:                fields.imm = immU;
            OpJal:                         fields.imm = immJ;
            default:                       fields.imm = '0; // R types have none.
        endcase
    end

endmodule

// File: src/opDecoder.sv
`timescale 1ns/1ps

module opDecoder (
    input  rvIsaPkg::instFields_t fields,
    output idCtrlPkg::ctrl_t      ctrl
);
    import rvIsaPkg::*;
    import idCtrlPkg::*;

    logic       illegal;
    logic [5:0] funct6;

    assign funct6 = fields.funct7[6:1]; // Bit 25 is shamt[5] for RV64 shifts.

    always_comb begin
        ctrl    = '{exeOp: ExeNop, exeSrc: SrcNop, memOp: MemNop, wbSel: WbNone, trap: TrapNone};
        illegal = 1'b0;
        case (fields.opcode)
            OpR: begin
                ctrl.exeSrc = SrcRegReg;
                ctrl.wbSel  = WbExe;
                case ({fields.funct7, fields.funct3})
                    {F7Base, F3Add}:  ctrl.exeOp = Add;
                    {F7Alt,  F3Add}:  ctrl.exeOp = Sub;
                    {F7Base, F3Sll}:  ctrl.exeOp = Sll;
                    {F7Base, F3Sr}:   ctrl.exeOp = Srl;
                    {F7Alt,  F3Sr}:   ctrl.exeOp = Sra;
                    {F7Base, F3Xor}:  ctrl.exeOp = Xor;
                    {F7Base, F3Or}:   ctrl.exeOp = Or;
                    {F7Base, F3And}:  ctrl.exeOp = And;
                    {F7Base, F3Slt}:  ctrl.exeOp = Slt;
                    {F7Base, F3Sltu}: ctrl.exeOp = Sltu;
                    default:          illegal = 1'b1;
                endcase
            end
            OpRW: begin
                ctrl.exeSrc = SrcRegReg;
                ctrl.wbSel  = WbExe;
                case ({fields.funct7, fields.funct3})
                    {F7Base, F3Add}: ctrl.exeOp = AddW;
                    {F7Alt,  F3Add}: ctrl.exeOp = SubW;
                    {F7Base, F3Sll}: ctrl.exeOp = SllW;
                    {F7Base, F3Sr}:  ctrl.exeOp = SrlW;
                    {F7Alt,  F3Sr}:  ctrl.exeOp = SraW;
                    default:         illegal = 1'b1;
                endcase
            end
            OpImm: begin
                ctrl.exeSrc = SrcRegImm;
                ctrl.wbSel  = WbExe;
                case (fields.funct3)
                    F3Add:  ctrl.exeOp = Add;
                    F3Xor:  ctrl.exeOp = Xor;
                    F3Or:   ctrl.exeOp = Or;
                    F3And:  ctrl.exeOp = And;
                    F3Slt:  ctrl.exeOp = Slt;
                    F3Sltu: ctrl.exeOp = Sltu;
                    F3Sll:  begin
                        if (funct6 == F6Base) ctrl.exeOp = Sll;
                        else illegal = 1'b1;
                    end
                    default: begin
                        if (funct6 == F6Base) ctrl.exeOp = Srl;
                        else if (funct6 == F6Alt) ctrl.exeOp = Sra;
                        else illegal = 1'b1;
                    end
                endcase
            end
            OpImmW: begin
                // The full funct7 is matched, so a shamt above 31 is rejected.
                ctrl.exeSrc = SrcRegImm;
                ctrl.wbSel  = WbExe;
                case ({fields.funct7, fields.funct3}) inside
                    {7'b???????, F3Add}: ctrl.exeOp = AddW;
                    {F7Base, F3Sll}:     ctrl.exeOp = SllW;
                    {F7Base, F3Sr}:      ctrl.exeOp = SrlW;
                    {F7Alt,  F3Sr}:      ctrl.exeOp = SraW;
                    default:             illegal = 1'b1;
                endcase
            end
            OpLoad: begin
                ctrl.exeOp  = Add;
                ctrl.exeSrc = SrcRegImm;
                ctrl.wbSel  = WbMem;
                case (fields.funct3)
                    F3Lb:    ctrl.memOp = Lb;
                    F3Lh:    ctrl.memOp = Lh;
                    F3Lw:    ctrl.memOp = Lw;
                    F3Ld:    ctrl.memOp = Ld;
                    F3Lbu:   ctrl.memOp = Lbu;
                    F3Lhu:   ctrl.memOp = Lhu;
                    F3Lwu:   ctrl.memOp = Lwu;
                    default: illegal = 1'b1;
                endcase
            end
            OpStore: begin
                ctrl.exeOp  = Add; // Address is rs1 + S immediate.
                ctrl.exeSrc = SrcRegImm;
                case (fields.funct3)
                    F3Sb:    ctrl.memOp = Sb;
                    F3Sh:    ctrl.memOp = Sh;
                    F3Sw:    ctrl.memOp = Sw;
                    F3Sd:    ctrl.memOp = Sd;
                    default: illegal = 1'b1;
                endcase
            end
            OpBranch: begin
                // Branches resolve in decode and need no execute work.
                if (fields.funct3 == 3'b010 || fields.funct3 == 3'b011) illegal = 1'b1;
            end
            OpJal:   ctrl.wbSel = WbSnpc;
            OpJalr: begin
                if (fields.funct3 == F3Jalr) ctrl.wbSel = WbSnpc;
                else illegal = 1'b1;
            end
            OpLui:   ctrl.wbSel = WbImm;
            OpAuipc: begin
                ctrl.exeOp  = Add;
                ctrl.exeSrc = SrcPcImm;
                ctrl.wbSel  = WbExe;
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            ctrl = '{exeOp: ExeNop, exeSrc: SrcNop, memOp: MemNop, wbSel: WbNone,
                     trap: TrapIllegal};
        end
    end

endmodule

// File: src/branchResolve.sv
`timescale 1ns/1ps

module branchResolve #(
    parameter int Xlen = rvIsaPkg::XLEN
) (
    input  rvIsaPkg::instFields_t fields,
    input  logic [Xlen-1:0]       pc,
    input  logic [Xlen-1:0]       rs1Data,
    input  logic [Xlen-1:0]       rs2Data,
    output logic [Xlen-1:0]       nextPc,
    output logic                  redirect
);
    import rvIsaPkg::*;

    localparam logic [Xlen-1:0] InstBytes = Xlen'(4);

    logic            taken;
    logic [Xlen-1:0] jalrSum;

    assign jalrSum = rs1Data + fields.imm;

    always_comb begin
        case (fields.funct3)
            F3Beq:   taken = rs1Data == rs2Data;
            F3Bne:   taken = rs1Data != rs2Data;
            F3Blt:   taken = $signed(rs1Data) < $signed(rs2Data);
            F3Bge:   taken = $signed(rs1Data) >= $signed(rs2Data);
            F3Bltu:  taken = rs1Data < rs2Data;
            F3Bgeu:  taken = rs1Data >= rs2Data;
            default: taken = 1'b0;
        endcase
    end

    // Every control transfer redirects fetch, even a branch that falls through.
    always_comb begin
        nextPc   = '0;
        redirect = 1'b0;
        case (fields.opcode)
            OpBranch: begin
                nextPc   = taken ? pc + fields.imm : pc + InstBytes;
                redirect = 1'b1;
            end
            OpJal: begin
                nextPc   = pc + fields.imm;
                redirect = 1'b1;
            end
            OpJalr: begin
                nextPc   = {jalrSum[Xlen-1:1], 1'b0}; // Target LSB is always cleared.
                redirect = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: src/idExeReg.sv
`timescale 1ns/1ps

module idExeReg (
    input  logic              clk,
    input  logic              rstN,
    input  logic              valid,
    input  logic              conflict,
    input  logic              exeReady,
    input  idCtrlPkg::idExe_t bundleIn,
    output logic              ready,
    output logic              outValid,
    output idCtrlPkg::idExe_t outBundle
);

    logic accept;

    // A conflict keeps the instruction in decode and sends a bubble instead.
    assign accept = valid && !conflict;

    // With nothing to decode, fetch is free to present the next instruction.
    assign ready = !valid || (accept && exeReady);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid  <= 1'b0;
            outBundle <= '0;
        end else if (exeReady) begin
            outValid  <= accept;
            outBundle <= accept ? bundleIn : '0;
        end
        // Execute is busy, so the current bundle stays in place.
    end

endmodule

// File: src/idStage.sv
`timescale 1ns/1ps

module idStage #(
    parameter int Xlen = rvIsaPkg::XLEN
) (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [rvIsaPkg::InstWidth-1:0]   inst,
    input  logic [Xlen-1:0]                  pc,
    input  logic                             valid,
    input  logic [Xlen-1:0]                  rs1Data,
    input  logic [Xlen-1:0]                  rs2Data,
    input  logic                             conflict,
    input  logic                             exeReady,
    output logic [rvIsaPkg::RegIdxWidth-1:0] rs1,
    output logic [rvIsaPkg::RegIdxWidth-1:0] rs2,
    output logic                             ready,
    output logic                             outValid,
    output idCtrlPkg::idExe_t                outBundle
);
    import rvIsaPkg::*;
    import idCtrlPkg::*;

    instFields_t     fields;
    ctrl_t           ctrl;
    logic [Xlen-1:0] nextPc;
    logic            redirect;
    idExe_t          bundle;

    instFields uFields (.inst(inst), .fields(fields));

    opDecoder uDecoder (.fields(fields), .ctrl(ctrl));

    branchResolve #(.Xlen(Xlen)) uBranch (
        .fields  (fields),
        .pc      (pc),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .nextPc  (nextPc),
        .redirect(redirect)
    );

    // Register indices go straight to the register file in the same cycle.
    assign rs1 = fields.rs1;
    assign rs2 = fields.rs2;

    always_comb begin
        bundle.ctrl     = ctrl;
        bundle.rd       = fields.rd;
        bundle.rs1Data  = rs1Data;
        bundle.rs2Data  = rs2Data;
        bundle.imm      = fields.imm;
        bundle.pc       = pc;
        bundle.nextPc   = nextPc;
        bundle.redirect = redirect;
    end

    idExeReg uIdExe (
        .clk      (clk),
        .rstN     (rstN),
        .valid    (valid),
        .conflict (conflict),
        .exeReady (exeReady),
        .bundleIn (bundle),
        .ready    (ready),
        .outValid (outValid),
        .outBundle(outBundle)
    );

endmodule

// File: tb/idStageTb.sv
`timescale 1ns/1ps

module idStageTb;
    import rvIsaPkg::*;
    import idCtrlPkg::*;

    localparam int    NumPatterns      = 19;
    localparam int    WordsPerPattern  = 9;
    localparam int    ResetCycles      = 16;
    localparam int    CyclesPerPattern = 40;
    localparam int    ClkPeriod        = 10;
    localparam int    RandSeed         = 10;
    localparam string PatternFile      = "tb/idPatterns.hex";

    // Column order of one pattern row.
    localparam int WInst     = 0;
    localparam int WPc       = 1;
    localparam int WRs1      = 2;
    localparam int WRs2      = 3;
    localparam int WCtrl     = 4;
    localparam int WImm      = 5;
    localparam int WNextPc   = 6;
    localparam int WRedirect = 7;
    localparam int WRd       = 8;

    logic                   clk;
    logic                   rstN;
    logic [InstWidth-1:0]   inst;
    logic [XLEN-1:0]        pc;
    logic                   valid;
    logic [XLEN-1:0]        rs1Data;
    logic [XLEN-1:0]        rs2Data;
    logic                   conflict;
    logic                   exeReady;
    logic [RegIdxWidth-1:0] rs1;
    logic [RegIdxWidth-1:0] rs2;
    logic                   ready;
    logic                   outValid;
    idExe_t                 outBundle;

    logic [63:0] patMem [0:NumPatterns*WordsPerPattern-1];
    int          expQ[$]; // Pattern rows accepted by decode, oldest first.

    idStage #(.Xlen(XLEN)) DUT (
        .clk      (clk),
        .rstN     (rstN),
        .inst     (inst),
        .pc       (pc),
        .valid    (valid),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .conflict (conflict),
        .exeReady (exeReady),
        .rs1      (rs1),
        .rs2      (rs2),
        .ready    (ready),
        .outValid (outValid),
        .outBundle(outBundle)
    );

    initial clk = 1'b0;
    always #(ClkPeriod / 2) clk = ~clk;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (actual === expected) else begin
            stopWithFailure($sformatf("** Error %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    function automatic logic [63:0] patWord(input int idx, input int word);
        return patMem[idx * WordsPerPattern + word];
    endfunction

    task automatic applyPattern(input int idx);
        inst    = InstWidth'(patWord(idx, WInst));
        pc      = patWord(idx, WPc);
        rs1Data = patWord(idx, WRs1);
        rs2Data = patWord(idx, WRs2);
    endtask

    task automatic checkBundle(input int idx);
        string tag;
        tag = $sformatf("pattern %0d", idx);
        checkValue({tag, " ctrl"}, patWord(idx, WCtrl), 64'(outBundle.ctrl));
        checkValue({tag, " rd"}, patWord(idx, WRd), 64'(outBundle.rd));
        checkValue({tag, " imm"}, patWord(idx, WImm), outBundle.imm);
        checkValue({tag, " nextPc"}, patWord(idx, WNextPc), outBundle.nextPc);
        checkValue({tag, " redirect"}, patWord(idx, WRedirect), 64'(outBundle.redirect));
        checkValue({tag, " pc"}, patWord(idx, WPc), outBundle.pc);
        checkValue({tag, " rs1Data"}, patWord(idx, WRs1), outBundle.rs1Data);
        checkValue({tag, " rs2Data"}, patWord(idx, WRs2), outBundle.rs2Data);
    endtask

    initial begin
        #((ResetCycles + NumPatterns * CyclesPerPattern) * ClkPeriod);
        stopWithFailure("Timeout: the decode stage did not deliver every pattern in time.");
    end

    initial begin
        int   p;
        int   idx;
        int   nextPat;
        int   checked;
        logic pending;
        logic modelValid;
        logic expReady;

        void'($urandom(RandSeed));
        rstN     = 1'b0;
        valid    = 1'b0;
        inst     = '0;
        pc       = '0;
        rs1Data  = '0;
        rs2Data  = '0;
        conflict = 1'b0;
        exeReady = 1'b0;
        $readmemh(PatternFile, patMem);
        for (p = 0; p < NumPatterns; p++) begin
            assert (patWord(p, WInst) != 64'd0) else begin
                stopWithFailure("The pattern file holds fewer rows than expected.");
            end
        end

        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        assert (outValid === 1'b0 && outBundle === '0) else begin
            stopWithFailure("Output register is not cleared during reset.");
        end
        rstN = 1'b1;

        nextPat    = 0;
        checked    = 0;
        pending    = 1'b0;
        modelValid = 1'b0;
        while (checked < NumPatterns) begin
            if (!pending && nextPat < NumPatterns && $urandom_range(0, 3) != 0) begin
                pending = 1'b1;
                applyPattern(nextPat);
            end
            valid    = pending;
            conflict = ($urandom_range(0, 3) == 0);
            exeReady = ($urandom_range(0, 3) != 0);
            #(ClkPeriod / 2 - 1); // Sample just ahead of the rising edge.

            expReady = !valid || (!conflict && exeReady);
            checkValue("ready", 64'(expReady), 64'(ready));
            checkValue("outValid", 64'(modelValid), 64'(outValid));
            checkValue("rs1 index", 64'(inst[19:15]), 64'(rs1));
            checkValue("rs2 index", 64'(inst[24:20]), 64'(rs2));

            if (outValid && exeReady) begin
                assert (expQ.size() > 0) else begin
                    stopWithFailure("An output appeared with no accepted instruction.");
                end
                idx = expQ.pop_front();
                checkBundle(idx);
                checked++;
            end
            if (valid && ready) begin
                expQ.push_back(nextPat);
                nextPat++;
                pending = 1'b0;
            end
            if (exeReady) modelValid = valid && !conflict; // Otherwise execute holds it.
            @(negedge clk);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: tb/idPatterns.hex
// inst pc rs1Data rs2Data ctrl imm nextPc redirect rd
// ctrl is {exeOp[14:10], exeSrc[9:8], memOp[7:4], wbSel[3:1], trap[0]}
002081B3 1000 5 7 502 0 0 0 3
407302B3 1004 10 3 902 0 0 0 5
FFB58513 1008 20 0 602 FFFFFFFFFFFFFFFB 0 0 A
42315093 100C FFFFFFFFFFFFFF00 0 1602 423 0 0 1
0062823B 1010 1 2 2D02 0 0 0 4
4034539B 1014 80000000 0 3E02 403 0 0 7
FF813483 1018 8000 0 644 FFFFFFFFFFFFFFF8 0 0 9
0101C603 101C 100 0 654 10 0 0 C
00532A23 1020 200 55 6A0 14 0 0 14
FE713823 1024 300 66 6B0 FFFFFFFFFFFFFFF0 0 0 10
00208863 2000 42 42 0 10 2010 1 10
FE41C0E3 2100 5 FFFFFFFFFFFFFFFF 0 FFFFFFFFFFFFFFE0 2104 1 1
0041F463 2200 FFFFFFFFFFFFFFFF 1 0 8 2208 1 8
001000EF 3000 0 0 6 800 3800 1 1
007302E7 3100 4000 0 6 7 4006 1 5
80000137 1028 0 0 8 FFFFFFFF80000000 0 0 2
12345197 102C 0 0 702 12345000 0 0 3
0000057F 1030 0 0 1 0 0 0 A
0210909B 1034 9 0 1 21 0 0 1

// File: build.f
src/rvIsaPkg.sv
src/idCtrlPkg.sv
src/instFields.sv
src/opDecoder.sv
src/branchResolve.sv
src/idExeReg.sv
src/idStage.sv
tb/idStageTb.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
TOP        := idStageTb
RTL_TOP    := idStage
FILELIST   := build.f
OBJ_DIR    := obj_dir
PASS_TEXT  := Simulation passed

.PHONY: all build lint clean

all: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
